// ==== include/mecobo_macros.svh ====
`ifndef MECOBO_MACROS_SVH
`define MECOBO_MACROS_SVH

// pin controllers on the board
`define NUM_PINS 4

// internal word address width, low bits of the host address
`define ADDR_W 16

// pin register block, PIN_STRIDE words per pin
`define PIN_BASE 16'h0032
`define PIN_STRIDE 4
`define PIN_MODE 0
`define PIN_PERIOD 1
`define PIN_HIGH_TICKS 2
`define PIN_CUR_TICK 3

// dac registers
`define DAC_BASE 16'h0100
`define DAC_DATA 0
`define DAC_STATUS 1

`endif

// ==== source/mecobo_pkg.sv ====
package mecobo_pkg;

  // output waveform per pin
  typedef enum logic [1:0] {
    PIN_OFF    = 2'd0,
    PIN_SQUARE = 2'd1,
    PIN_PWM    = 2'd2,
    PIN_HIGH   = 2'd3
  } pin_mode_e;

  // field layout of the MODE word, mode in the low bits
  typedef struct packed {
    logic [12:0] reserved;
    logic        invert;
    pin_mode_e   mode;
  } pin_mode_fields_t;

  // MODE register as the bus writes it, or split into fields
  typedef union packed {
    logic [15:0]      raw;
    pin_mode_fields_t f;
  } pin_mode_u;

  // serial dac transfer phases
  typedef enum logic [1:0] {
    DAC_IDLE  = 2'd0,
    DAC_SHIFT = 2'd1,
    DAC_LOAD  = 2'd2
  } dac_state_e;

endpackage

// ==== source/reg_bus_if.sv ====
`timescale 1ns/1ns
`include "mecobo_macros.svh"

// single-cycle register access from the host bridge to the targets
interface reg_bus_if;
  logic                wr;
  logic                rd;
  logic [`ADDR_W-1:0]  addr;
  logic [15:0]         wdata;

  modport host (
    output wr,
    output rd,
    output addr,
    output wdata
  );

  modport target (
    input wr,
    input rd,
    input addr,
    input wdata
  );

endinterface

// ==== source/host_bus_bridge.sv ====
`timescale 1ns/1ns
`include "mecobo_macros.svh"

module host_bus_bridge (
  input  logic                       sys_clk,
  input  logic                       reset,
  input  logic                       cs_n,
  input  logic                       wr_n,
  input  logic                       rd_n,
  input  logic [18:0]                addr,
  input  logic [15:0]                data_in,
  output logic [15:0]                data_out,
  output logic                       data_oe,
  reg_bus_if.host                    bus,
  input  logic [`NUM_PINS:0][15:0]   rdata
);

  // strobes as active high, bit order cs, wr, rd
  logic [2:0]  strb_s1;
  logic [2:0]  strb_s2;
  logic        wr_act;
  logic        rd_act;
  logic        wr_act_q;
  logic        rd_act_q;
  logic        wr_rise;
  logic        rd_rise;
  logic        rd_pend;
  logic [15:0] rdata_or;

  assign wr_act  = strb_s2[2] & strb_s2[1];
  assign rd_act  = strb_s2[2] & strb_s2[0];
  assign wr_rise = wr_act & ~wr_act_q;
  assign rd_rise = rd_act & ~rd_act_q;

  // drive the data pins for as long as the host holds the read
  assign data_oe = rd_act;

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      strb_s1  <= '0;
      strb_s2  <= '0;
      wr_act_q <= 1'b0;
      rd_act_q <= 1'b0;
      bus.wr   <= 1'b0;
      bus.rd   <= 1'b0;
      rd_pend  <= 1'b0;
    end else begin
      strb_s1  <= ~{cs_n, wr_n, rd_n};
      strb_s2  <= strb_s1;
      wr_act_q <= wr_act;
      rd_act_q <= rd_act;
      bus.wr   <= wr_rise;
      bus.rd   <= rd_rise;
      // targets answer one cycle after the read pulse
      rd_pend  <= bus.rd;
    end
  end

  // address and data are stable while the strobe is held
  always_ff @(posedge sys_clk) begin
    if (wr_rise || rd_rise) begin
      bus.addr  <= addr[`ADDR_W-1:0];
      bus.wdata <= data_in;
    end
  end

  // unaddressed targets return zero
  always_comb begin
    rdata_or = '0;
    for (int i = 0; i <= `NUM_PINS; i++) begin
      rdata_or = rdata_or | rdata[i];
    end
  end

  // held until the next read completes
  always_ff @(posedge sys_clk) begin
    if (rd_pend) begin
      data_out <= rdata_or;
    end
  end

endmodule

// ==== source/pin_control.sv ====
`timescale 1ns/1ns
`include "mecobo_macros.svh"

module pin_control #(
  parameter int POSITION = 0
) (
  input  logic        sys_clk,
  input  logic        reset,
  reg_bus_if.target   bus,
  output logic [15:0] rdata,
  output logic        pin
);

  import mecobo_pkg::*;

  localparam int unsigned BASE_ADDR = `PIN_BASE + POSITION * `PIN_STRIDE;

  logic [`ADDR_W-1:0] rel;
  logic               hit;
  logic [1:0]         offset;

  pin_mode_u   mode_q;
  logic [15:0] period_q;
  logic [15:0] high_q;
  logic [15:0] tick_q;
  logic        level;

  // word offset inside this pin's block
  assign rel    = bus.addr - BASE_ADDR[`ADDR_W-1:0];
  assign hit    = (rel < `PIN_STRIDE);
  assign offset = rel[1:0];

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      mode_q.raw <= '0;
      period_q   <= '0;
      high_q     <= '0;
    end else if (bus.wr && hit) begin
      case (offset)
        `PIN_MODE:       mode_q.raw <= bus.wdata;
        `PIN_PERIOD:     period_q   <= bus.wdata;
        `PIN_HIGH_TICKS: high_q     <= bus.wdata;
        // current tick is read only
        default: ;
      endcase
    end
  end

  // tick counter, zero period parks it at 0
  always_ff @(posedge sys_clk) begin
    if (reset) begin
      tick_q <= '0;
    end else if (period_q == '0 || tick_q >= period_q - 16'd1) begin
      tick_q <= '0;
    end else begin
      tick_q <= tick_q + 16'd1;
    end
  end

  // waveform level for the current tick
  always_comb begin
    case (mode_q.f.mode)
      PIN_SQUARE: level = (tick_q < (period_q >> 1));
      PIN_PWM:    level = (tick_q < high_q);
      PIN_HIGH:   level = 1'b1;
      default:    level = 1'b0;
    endcase
  end

  // pin lags the counter by one cycle
  always_ff @(posedge sys_clk) begin
    if (reset) begin
      pin <= 1'b0;
    end else begin
      pin <= level ^ mode_q.f.invert;
    end
  end

  // read word, zero when another target is addressed
  always_ff @(posedge sys_clk) begin
    if (bus.rd) begin
      if (!hit) begin
        rdata <= '0;
      end else begin
        case (offset)
          `PIN_MODE:       rdata <= mode_q.raw;
          `PIN_PERIOD:     rdata <= period_q;
          `PIN_HIGH_TICKS: rdata <= high_q;
          default:         rdata <= tick_q;
        endcase
      end
    end
  end

endmodule

// ==== source/dac_control.sv ====
`timescale 1ns/1ns
`include "mecobo_macros.svh"

module dac_control (
  input  logic        sys_clk,
  input  logic        reset,
  reg_bus_if.target   bus,
  output logic [15:0] rdata,
  output logic        sclk,
  output logic        sync_n,
  output logic        ldac_n,
  output logic        din
);

  import mecobo_pkg::*;

  dac_state_e  state;
  logic [15:0] data_q;
  logic [3:0]  bit_cnt;
  logic        phase;
  logic        busy;
  logic        data_sel;
  logic        status_sel;

  assign data_sel   = (bus.addr == `DAC_BASE + `DAC_DATA);
  assign status_sel = (bus.addr == `DAC_BASE + `DAC_STATUS);
  assign busy       = (state != DAC_IDLE);

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      state   <= DAC_IDLE;
      bit_cnt <= '0;
      phase   <= 1'b0;
      sclk    <= 1'b0;
      sync_n  <= 1'b1;
      ldac_n  <= 1'b1;
      din     <= 1'b0;
    end else begin
      case (state)
        DAC_IDLE: begin
          // writes while busy never reach this branch
          if (bus.wr && data_sel) begin
            state   <= DAC_SHIFT;
            bit_cnt <= 4'd15;
            phase   <= 1'b0;
            sclk    <= 1'b1;
            sync_n  <= 1'b0;
            din     <= bus.wdata[15];
          end
        end
        DAC_SHIFT: begin
          if (!phase) begin
            // falling edge, dac samples din here
            sclk  <= 1'b0;
            phase <= 1'b1;
          end else if (bit_cnt == 4'd0) begin
            state  <= DAC_LOAD;
            sync_n <= 1'b1;
            ldac_n <= 1'b0;
          end else begin
            bit_cnt <= bit_cnt - 4'd1;
            phase   <= 1'b0;
            sclk    <= 1'b1;
            din     <= data_q[bit_cnt - 4'd1];
          end
        end
        default: begin
          // single ldac strobe then back to idle
          ldac_n <= 1'b1;
          state  <= DAC_IDLE;
        end
      endcase
    end
  end

  // last accepted word, also the shift source
  always_ff @(posedge sys_clk) begin
    if (bus.wr && data_sel && !busy) begin
      data_q <= bus.wdata;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (bus.rd) begin
      if (data_sel) begin
        rdata <= data_q;
      end else if (status_sel) begin
        rdata <= {15'b0, busy};
      end else begin
        rdata <= '0;
      end
    end
  end

endmodule

// ==== source/mecobo_top.sv ====
`timescale 1ns/1ns
`include "mecobo_macros.svh"

module mecobo_top (
  input  logic                 sys_clk,
  input  logic                 reset,
  input  logic                 ebi_cs_n,
  input  logic                 ebi_wr_n,
  input  logic                 ebi_rd_n,
  input  logic [18:0]          ebi_addr,
  input  logic [15:0]          ebi_data_in,
  output logic [15:0]          ebi_data_out,
  output logic                 ebi_data_oe,
  output logic                 fpga_ready,
  output logic [`NUM_PINS-1:0] pin,
  output logic                 dac_sclk,
  output logic                 dac_sync_n,
  output logic                 dac_ldac_n,
  output logic                 dac_din
);

  // one read word per pin, dac word on top
  logic [`NUM_PINS:0][15:0] rdata;

  reg_bus_if reg_bus ();

  assign fpga_ready = 1'b1;

  host_bus_bridge u_bridge (
    .sys_clk  (sys_clk),
    .reset    (reset),
    .cs_n     (ebi_cs_n),
    .wr_n     (ebi_wr_n),
    .rd_n     (ebi_rd_n),
    .addr     (ebi_addr),
    .data_in  (ebi_data_in),
    .data_out (ebi_data_out),
    .data_oe  (ebi_data_oe),
    .bus      (reg_bus),
    .rdata    (rdata)
  );

  for (genvar i = 0; i < `NUM_PINS; i++) begin : g_pin
    pin_control #(.POSITION(i)) u_pin (
      .sys_clk (sys_clk),
      .reset   (reset),
      .bus     (reg_bus),
      .rdata   (rdata[i]),
      .pin     (pin[i])
    );
  end

  dac_control u_dac (
    .sys_clk (sys_clk),
    .reset   (reset),
    .bus     (reg_bus),
    .rdata   (rdata[`NUM_PINS]),
    .sclk    (dac_sclk),
    .sync_n  (dac_sync_n),
    .ldac_n  (dac_ldac_n),
    .din     (dac_din)
  );

endmodule

// ==== test/mecobo_assert.sv ====
`timescale 1ns/1ns

module mecobo_assert (
  input logic sys_clk,
  input logic reset,
  input logic wr,
  input logic rd,
  input logic sync_n
);

  // cycles sync_n has been low in the current transfer
  int low_cnt;

  always_ff @(posedge sys_clk) begin
    if (reset || sync_n) begin
      low_cnt <= 0;
    end else begin
      low_cnt <= low_cnt + 1;
    end
  end

  never_both: assert property (@(posedge sys_clk) disable iff (reset) !(wr && rd))
    else $error("wr and rd pulses in the same cycle");

  wr_single: assert property (@(posedge sys_clk) disable iff (reset) wr |=> !wr)
    else $error("wr pulse longer than one cycle");

  rd_single: assert property (@(posedge sys_clk) disable iff (reset) rd |=> !rd)
    else $error("rd pulse longer than one cycle");

  // 16 bits at two cycles each
  sync_len: assert property (@(posedge sys_clk) disable iff (reset)
    $rose(sync_n) |-> low_cnt == 32)
    else $error("dac sync_n low for %0d cycles instead of 32", low_cnt);

  sync_bound: assert property (@(posedge sys_clk) disable iff (reset)
    !sync_n |-> low_cnt < 32)
    else $error("dac sync_n held low too long");

endmodule

// wr and rd are the bridge pulses as the dac target receives them
bind dac_control mecobo_assert u_dac_assert (
  .sys_clk (sys_clk),
  .reset   (reset),
  .wr      (bus.wr),
  .rd      (bus.rd),
  .sync_n  (sync_n)
);

// ==== test/mecobo_tb.sv ====
`timescale 1ns/1ns
`include "mecobo_macros.svh"

module mecobo_tb;

  import mecobo_pkg::*;

  // tests need under 2000 cycles, the rest is margin
  localparam int MAX_CYCLES = 6000;
  localparam logic [15:0] DAC_DATA_ADDR = 16'(`DAC_BASE + `DAC_DATA);
  localparam logic [15:0] DAC_STATUS_ADDR = 16'(`DAC_BASE + `DAC_STATUS);

  logic                 sys_clk = 1'b0;
  logic                 reset;
  logic                 ebi_cs_n;
  logic                 ebi_wr_n;
  logic                 ebi_rd_n;
  logic [18:0]          ebi_addr;
  logic [15:0]          ebi_data_in;
  logic [15:0]          ebi_data_out;
  logic                 ebi_data_oe;
  logic                 fpga_ready;
  logic [`NUM_PINS-1:0] pin;
  logic                 dac_sclk;
  logic                 dac_sync_n;
  logic                 dac_ldac_n;
  logic                 dac_din;

  int errors = 0;
  int tests = 0;
  int failed = 0;
  int errors_at_start = 0;
  int cycles = 0;
  // high-cycle monitor
  int mon_sel = 0;
  int mon_left = 0;
  int mon_cnt = 0;
  int mon_exp = 0;
  // serial capture, index 0 is the first bit on the wire
  logic [15:0] cap_bits;
  int cap_n = 0;
  int ldac_cnt = 0;

  mecobo_top dut (.*);

  always #5 sys_clk = ~sys_clk;

  always @(posedge sys_clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Errors found");
      $finish;
    end
  end

  // high cycles per period from the mode rules
  function automatic int exp_high_count(pin_mode_u m, int period, int high_ticks);
    int n;
    case (m.f.mode)
      PIN_SQUARE: n = period / 2;
      PIN_PWM:    n = (high_ticks < period) ? high_ticks : period;
      PIN_HIGH:   n = period;
      default:    n = 0;
    endcase
    if (m.f.invert) begin
      n = period - n;
    end
    return n;
  endfunction

  // msb goes out first
  function automatic logic [15:0] exp_dac_bits(logic [15:0] word);
    logic [15:0] bits;
    for (int i = 0; i < 16; i++) begin
      bits[i] = word[15 - i];
    end
    return bits;
  endfunction

  function automatic logic [15:0] pin_reg(int p, int offset);
    return 16'(`PIN_BASE + p * `PIN_STRIDE + offset);
  endfunction

  always @(negedge sys_clk) begin
    if (mon_left != 0) begin
      if (pin[mon_sel]) begin
        mon_cnt++;
      end
      mon_left--;
      if (mon_left == 0) begin
        assert (mon_cnt == mon_exp) else begin
          $display("Fail at %0t ns: pin %0d high for %0d cycles, expected %0d",
                   $time, mon_sel, mon_cnt, mon_exp);
          errors++;
        end
      end
    end
  end

  // dac samples on the falling serial clock
  always @(negedge dac_sclk) begin
    if (!dac_sync_n) begin
      if (cap_n < 16) begin
        cap_bits[cap_n] = dac_din;
      end
      cap_n++;
    end
  end

  always @(negedge dac_ldac_n) begin
    ldac_cnt++;
  end

  task automatic check_word(input string what, input logic [15:0] got, input logic [15:0] exp);
    assert (got === exp) else begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic bus_write(input logic [15:0] a, input logic [15:0] d);
    @(posedge sys_clk);
    #1;
    ebi_addr = {3'b0, a};
    ebi_data_in = d;
    ebi_cs_n = 1'b0;
    ebi_wr_n = 1'b0;
    repeat (6) @(posedge sys_clk);
    #1;
    ebi_cs_n = 1'b1;
    ebi_wr_n = 1'b1;
    repeat (2) @(posedge sys_clk);
  endtask

  task automatic bus_read(input logic [15:0] a, output logic [15:0] d);
    @(posedge sys_clk);
    #1;
    ebi_addr = {3'b0, a};
    ebi_cs_n = 1'b0;
    ebi_rd_n = 1'b0;
    repeat (5) @(posedge sys_clk);
    // last held cycle, data settled after five edges
    @(negedge sys_clk);
    d = ebi_data_out;
    assert (ebi_data_oe) else begin
      $display("read at %0t ns: data bus not driven while rd held", $time);
      errors++;
    end
    @(posedge sys_clk);
    #1;
    ebi_cs_n = 1'b1;
    ebi_rd_n = 1'b1;
    repeat (2) @(posedge sys_clk);
  endtask

  task automatic measure_pin(input int p, input int len, input int exp);
    @(posedge sys_clk);
    #1;
    mon_sel = p;
    mon_cnt = 0;
    mon_exp = exp;
    mon_left = len;
    wait (mon_left == 0);
  endtask

  task automatic dac_transfer(input logic [15:0] first, input bit overlap,
                              input logic [15:0] second);
    logic [15:0] rd;
    cap_n = 0;
    ldac_cnt = 0;
    bus_write(DAC_DATA_ADDR, first);
    if (overlap) begin
      bus_write(DAC_DATA_ADDR, second);
    end
    bus_read(DAC_STATUS_ADDR, rd);
    check_word("dac status during transfer", rd, 16'h0001);
    // poll busy, the cycle limit catches a stuck transfer
    while (rd[0]) begin
      bus_read(DAC_STATUS_ADDR, rd);
    end
    check_word("dac serial bits", cap_bits, exp_dac_bits(first));
    check_word("dac bit count", 16'(cap_n), 16'd16);
    check_word("ldac pulses", 16'(ldac_cnt), 16'd1);
    bus_read(DAC_DATA_ADDR, rd);
    check_word("dac data read-back", rd, first);
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors != errors_at_start) begin
      failed++;
      $display("test %0d %s: failed, %0d errors", tests, name, errors - errors_at_start);
    end else begin
      $display("test %0d %s: ok", tests, name);
    end
    errors_at_start = errors;
  endtask

  initial begin
    logic [15:0] rd;
    logic [15:0] word;
    int period;
    int high;
    int p;
    pin_mode_u mode_v;

    void'($urandom(32'h45cb_5b2f));
    reset = 1'b1;
    ebi_cs_n = 1'b1;
    ebi_wr_n = 1'b1;
    ebi_rd_n = 1'b1;
    ebi_addr = '0;
    ebi_data_in = '0;
    repeat (4) @(posedge sys_clk);
    #1;
    reset = 1'b0;

    check_word("pins after reset", 16'(pin), 16'h0000);
    // fpga_ready, sclk, sync_n, ldac_n, data_oe
    check_word("dac lines after reset",
               {11'b0, fpga_ready, dac_sclk, dac_sync_n, dac_ldac_n, ebi_data_oe},
               16'h0016);
    for (int i = 0; i < `NUM_PINS; i++) begin
      bus_read(pin_reg(i, `PIN_MODE), rd);
      check_word("mode after reset", rd, 16'h0000);
    end
    end_test("reset state");

    for (int i = 0; i < `NUM_PINS; i++) begin
      period = int'($urandom % 65536);
      high = int'($urandom % 65536);
      mode_v.raw = 16'($urandom);
      bus_write(pin_reg(i, `PIN_PERIOD), 16'(period));
      bus_write(pin_reg(i, `PIN_HIGH_TICKS), 16'(high));
      bus_write(pin_reg(i, `PIN_MODE), mode_v.raw);
      bus_read(pin_reg(i, `PIN_PERIOD), rd);
      check_word("period read-back", rd, 16'(period));
      bus_read(pin_reg(i, `PIN_HIGH_TICKS), rd);
      check_word("high ticks read-back", rd, 16'(high));
      bus_read(pin_reg(i, `PIN_MODE), rd);
      check_word("mode and invert read-back", rd & 16'h0007, mode_v.raw & 16'h0007);
    end
    end_test("register read-back");

    for (int i = 0; i < 2 * `NUM_PINS; i++) begin
      p = i % `NUM_PINS;
      period = 4 + int'($urandom % 37);
      high = int'($urandom % (period + 3));
      mode_v.raw = 16'($urandom);
      mode_v.f.mode = (i % 2 == 1) ? PIN_PWM : PIN_SQUARE;
      // second pass over the pins runs inverted
      mode_v.f.invert = (i >= `NUM_PINS);
      bus_write(pin_reg(p, `PIN_PERIOD), 16'(period));
      bus_write(pin_reg(p, `PIN_HIGH_TICKS), 16'(high));
      bus_write(pin_reg(p, `PIN_MODE), mode_v.raw);
      measure_pin(p, period, exp_high_count(mode_v, period, high));
    end
    end_test("square and pwm");

    for (int i = 0; i < `NUM_PINS; i++) begin
      period = 4 + int'($urandom % 37);
      mode_v.raw = '0;
      mode_v.f.mode = (i % 2 == 0) ? PIN_HIGH : PIN_OFF;
      bus_write(pin_reg(i, `PIN_PERIOD), 16'(period));
      bus_write(pin_reg(i, `PIN_MODE), mode_v.raw);
      measure_pin(i, 2 * period, 2 * exp_high_count(mode_v, period, 0));
      bus_read(pin_reg(i, `PIN_CUR_TICK), rd);
      assert (int'(rd) < period) else begin
        $display("Fail at %0t ns: pin %0d tick %0d not below period %0d",
                 $time, i, rd, period);
        errors++;
      end
    end
    end_test("high and off");

    word = 16'($urandom);
    dac_transfer(word, 1'b0, 16'h0000);
    end_test("dac transfer");

    word = 16'($urandom);
    dac_transfer(word, 1'b1, ~word);
    end_test("dac write while busy");

    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+include
source/mecobo_pkg.sv
source/reg_bus_if.sv
source/host_bus_bridge.sv
source/pin_control.sv
source/dac_control.sv
source/mecobo_top.sv
test/mecobo_assert.sv
test/mecobo_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module mecobo_tb -f sources.f

# the run passes only if the pass message was printed
./obj_dir/Vmecobo_tb | tee /dev/stderr | grep -qx "No errors"
echo "simulation passed"
